//--- common/ecc_defines.svh
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

////////////////////////////////////////
// word geometry of the 117-bit SECDED code.
////////////////////////////////////////

// data bits per word.
`define ECC_DATA_WIDTH   117

// seven Hamming check bits plus overall parity.
`define ECC_PARITY_WIDTH 8

// bits of a Hamming position (1 to 127).
`define ECC_POS_WIDTH    7

`endif

//--- common/ecc_pkg.sv
`include "ecc_defines.svh"

package ecc_pkg;

    ////////////////////////////////////////
    // vector types.
    ////////////////////////////////////////

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;     // one data word.
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;   // stored or regenerated check bits.
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_syndrome_t; // stored ^ regenerated.
    typedef logic [`ECC_POS_WIDTH-1:0]    ecc_index_t;    // data bit 0 to 116.

    ////////////////////////////////////////
    // error classes.
    ////////////////////////////////////////

    // a check-bit hit is single too, it just leaves the data alone.
    typedef enum logic [1:0] {
        ECC_CLEAN  = 2'd0,
        ECC_SINGLE = 2'd1,
        ECC_DOUBLE = 2'd2
    } ecc_err_e;

endpackage

//--- ecc_check/ecc_parity_gen.sv
`timescale 1ns/1ps
`include "ecc_defines.svh"

module ecc_parity_gen import ecc_pkg::*; (
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // Data bits fill the Hamming positions that are not powers of two,
    // starting at 3. Check bit i takes every data bit whose position has
    // bit i set; the top check bit takes the even-weight positions, which
    // makes every data column odd weight.
    always_comb begin
        ecc_index_t                idx;
        logic [`ECC_POS_WIDTH-1:0] pos;

        parity = '0;
        idx    = '0;
        for (int p = 3; p < (1 << `ECC_POS_WIDTH); p++) begin
            pos = p[`ECC_POS_WIDTH-1:0];
            if (((pos & (pos - 1'b1)) != '0) && (idx < `ECC_DATA_WIDTH)) begin
                for (int i = 0; i < `ECC_POS_WIDTH; i++) begin
                    if (pos[i]) begin
                        parity[i] = parity[i] ^ data[idx];
                    end
                end
                if (!(^pos)) begin                        // even weight.
                    parity[`ECC_PARITY_WIDTH-1] = parity[`ECC_PARITY_WIDTH-1] ^ data[idx];
                end
                idx = idx + 1'b1;                         // next data bit.
            end
        end
    end

endmodule

//--- ecc_check/ecc_check_stage.sv
`timescale 1ns/1ps

module ecc_check_stage import ecc_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  ecc_data_t     data_in,
    input  ecc_parity_t   parity_in,
    input  logic          bypass,
    output logic          s1_valid,
    output ecc_data_t     s1_data,
    output ecc_parity_t   s1_parity,
    output ecc_syndrome_t s1_syndrome,
    output logic          s1_bypass
);

    ecc_parity_t   gen_parity;
    ecc_syndrome_t syndrome;

    ecc_parity_gen i_parity_gen (
        .data   (data_in),
        .parity (gen_parity)
    );

    assign syndrome = parity_in ^ gen_parity;           // zero when the word is clean.

    ////////////////////////////////////////
    // stage 1 registers.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_data     <= data_in;
            s1_parity   <= gen_parity;                  // regenerated, not stored.
            s1_syndrome <= syndrome;
            s1_bypass   <= bypass;
        end
    end

    // nothing may leave stage 1 straight out of reset.
    a_valid_after_reset : assert property (
        @(posedge clk) reset |=> !s1_valid
    ) else $error("s1_valid high in the cycle after reset");

endmodule

//--- ecc_correct/ecc_syndrome_decode.sv
`timescale 1ns/1ps
`include "ecc_defines.svh"

module ecc_syndrome_decode import ecc_pkg::*; (
    input  ecc_syndrome_t syndrome,
    output ecc_err_e      err_class,
    output ecc_index_t    bit_index
);

    logic [`ECC_POS_WIDTH-1:0] pos;
    logic                      pos_pow2;
    logic                      pos_even;
    logic                      is_col;
    ecc_index_t                n_below;                 // check positions under pos.

    assign pos      = syndrome[`ECC_POS_WIDTH-1:0];
    assign pos_pow2 = (pos & (pos - 1'b1)) == '0;       // also true for zero.
    assign pos_even = ~^pos;

    // last data slot sits one check position per position bit past the data width.
    assign is_col = (pos >= 3)
                 && !pos_pow2
                 && (pos <= (`ECC_DATA_WIDTH + `ECC_POS_WIDTH))
                 && (syndrome[`ECC_PARITY_WIDTH-1] == pos_even);

    always_comb begin
        n_below = '0;
        for (int i = 0; i < `ECC_POS_WIDTH; i++) begin
            if ((1 << i) < pos) begin
                n_below = n_below + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // classify.
    ////////////////////////////////////////

    always_comb begin
        err_class = ECC_DOUBLE;
        bit_index = '0;
        if (syndrome == '0) begin
            err_class = ECC_CLEAN;
        end else if ($onehot(syndrome)) begin
            err_class = ECC_SINGLE;                     // check bit only.
        end else if (is_col) begin
            err_class = ECC_SINGLE;
            bit_index = pos - n_below - 1'b1;           // position to data index.
        end

        if (is_col) begin
            a_index_range : assert (bit_index < `ECC_DATA_WIDTH)
                else $error("bit_index %0d out of range for syndrome %h", bit_index, syndrome);
        end
    end

endmodule

//--- ecc_correct/ecc_correct_stage.sv
`timescale 1ns/1ps

module ecc_correct_stage import ecc_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          s1_valid,
    input  ecc_data_t     s1_data,
    input  ecc_parity_t   s1_parity,
    input  ecc_syndrome_t s1_syndrome,
    input  logic          s1_bypass,
    output logic          out_valid,
    output ecc_data_t     data_out,
    output ecc_parity_t   parity_out,
    output logic          sbit_err,
    output logic          dbit_err
);

    ecc_err_e   err_class;
    ecc_index_t bit_index;
    logic       data_fix;
    ecc_data_t  flip_mask;
    ecc_data_t  fixed_data;

    ecc_syndrome_decode i_syndrome_decode (
        .syndrome  (s1_syndrome),
        .err_class (err_class),
        .bit_index (bit_index)
    );

    // a one-hot syndrome is single too but points at a check bit.
    assign data_fix   = (err_class == ECC_SINGLE) && !$onehot(s1_syndrome) && !s1_bypass;
    assign flip_mask  = data_fix ? (ecc_data_t'(1) << bit_index) : '0;
    assign fixed_data = s1_data ^ flip_mask;

    ////////////////////////////////////////
    // output registers.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            sbit_err  <= s1_valid && !s1_bypass && (err_class == ECC_SINGLE);
            dbit_err  <= s1_valid && !s1_bypass && (err_class == ECC_DOUBLE);
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            data_out   <= fixed_data;                   // raw word under bypass.
            parity_out <= s1_parity;
        end
    end

    a_flags_exclusive : assert property (
        @(posedge clk) disable iff (reset) !(sbit_err && dbit_err)
    ) else $error("sbit_err and dbit_err both high");

endmodule

//--- design/ecc_117_top.sv
`timescale 1ns/1ps

module ecc_117_top import ecc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_in,
    input  logic        bypass,
    output logic        out_valid,
    output ecc_data_t   data_out,
    output ecc_parity_t parity_out,
    output logic        sbit_err,
    output logic        dbit_err
);

    // stage 1 to stage 2.
    logic          s1_valid;
    ecc_data_t     s1_data;
    ecc_parity_t   s1_parity;
    ecc_syndrome_t s1_syndrome;
    logic          s1_bypass;

    ecc_check_stage i_check_stage (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .data_in     (data_in),
        .parity_in   (parity_in),
        .bypass      (bypass),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass)
    );

    ecc_correct_stage i_correct_stage (
        .clk         (clk),
        .reset       (reset),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass),
        .out_valid   (out_valid),
        .data_out    (data_out),
        .parity_out  (parity_out),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

//--- sim/ecc_ref_model.svh
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

////////////////////////////////////////
// reference SECDED code, built bit by bit.
////////////////////////////////////////

// column of data bit k is its Hamming position with the even-weight flag on top.
function automatic logic [`ECC_PARITY_WIDTH-1:0] ref_column(input int k);
    logic [`ECC_POS_WIDTH-1:0]    pos;
    logic [`ECC_PARITY_WIDTH-1:0] col;
    int                           seen;

    pos  = 2;
    seen = -1;
    while (seen < k) begin
        pos = pos + 1'b1;
        if ($countones(pos) > 1) begin                  // powers of two hold check bits.
            seen = seen + 1;
        end
    end
    col[`ECC_POS_WIDTH-1:0]    = pos;
    col[`ECC_PARITY_WIDTH-1]   = ($countones(pos) % 2) == 0;
    return col;
endfunction

// check bits of a word are the XOR of the columns of its set bits.
function automatic logic [`ECC_PARITY_WIDTH-1:0] ref_check_bits(
    input logic [`ECC_DATA_WIDTH-1:0] data
);
    logic [`ECC_PARITY_WIDTH-1:0] chk;

    chk = '0;
    for (int k = 0; k < `ECC_DATA_WIDTH; k++) begin
        if (data[k]) begin
            chk = chk ^ ref_column(k);
        end
    end
    return chk;
endfunction

`endif

//--- sim/ecc_117_tb.sv
`timescale 1ns/1ps
`include "ecc_defines.svh"

module ecc_117_tb import ecc_pkg::*; ();

    `include "ecc_ref_model.svh"

    localparam int PAT_ZERO = 0;
    localparam int PAT_ONES = 1;
    localparam int PAT_RAND = 2;

    localparam int KIND_NONE        = 0;
    localparam int KIND_DATA        = 1;
    localparam int KIND_CHECK       = 2;
    localparam int KIND_DATA_DATA   = 3;
    localparam int KIND_DATA_CHECK  = 4;
    localparam int KIND_CHECK_CHECK = 5;

    localparam int MAX_ROWS = 64;
    localparam int TIMEOUT  = 20;

    typedef struct packed {
        logic [31:0] test_id;
        logic [31:0] exp_cyc;
        ecc_data_t   data;
        ecc_parity_t parity;
        logic        sbit;
        logic        dbit;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    ecc_data_t   data_in;
    ecc_parity_t parity_in;
    logic        bypass;
    logic        out_valid;
    ecc_data_t   data_out;
    ecc_parity_t parity_out;
    logic        sbit_err;
    logic        dbit_err;

    // stimulus table.
    string tbl_name [MAX_ROWS];
    int    tbl_pat  [MAX_ROWS];
    int    tbl_kind [MAX_ROWS];
    int    tbl_a    [MAX_ROWS];
    int    tbl_b    [MAX_ROWS];
    logic  tbl_byp  [MAX_ROWS];
    int    n_rows = 0;

    expect_t     exp_q[$];
    logic [31:0] cyc = '0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          other_errors = 0;
    int          wait_cycles;
    int          seed_init;
    logic        row_bad;

    ecc_117_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #4 clk = ~clk;                               // 8 ns period.

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////
    // helpers.
    ////////////////////////////////////////

    task automatic add_row(input string name, input int pat, input int kind,
                           input int a, input int b, input logic byp);
        tbl_name[n_rows] = name;
        tbl_pat[n_rows]  = pat;
        tbl_kind[n_rows] = kind;
        tbl_a[n_rows]    = a;
        tbl_b[n_rows]    = b;
        tbl_byp[n_rows]  = byp;
        n_rows = n_rows + 1;
    endtask

    function automatic ecc_data_t random_word();
        logic [127:0] w;

        w = {$urandom, $urandom, $urandom, $urandom};
        return w[`ECC_DATA_WIDTH-1:0];
    endfunction

    task automatic build_table();
        int a;
        int b;

        add_row("clean zero", PAT_ZERO, KIND_NONE, 0, 0, 1'b0);
        add_row("clean ones", PAT_ONES, KIND_NONE, 0, 0, 1'b0);
        add_row("clean random", PAT_RAND, KIND_NONE, 0, 0, 1'b0);
        add_row("clean random", PAT_RAND, KIND_NONE, 0, 0, 1'b0);
        add_row("data flip", PAT_RAND, KIND_DATA, 0, 0, 1'b0);
        add_row("data flip", PAT_RAND, KIND_DATA, 1, 0, 1'b0);
        add_row("data flip", PAT_RAND, KIND_DATA, 3, 0, 1'b0);
        add_row("data flip", PAT_RAND, KIND_DATA, 58, 0, 1'b0);
        add_row("data flip", PAT_RAND, KIND_DATA, 116, 0, 1'b0);
        add_row("data flip ones", PAT_ONES, KIND_DATA, 116, 0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            add_row("data flip random", PAT_RAND, KIND_DATA, $urandom % 117, 0, 1'b0);
        end
        for (int i = 0; i < `ECC_PARITY_WIDTH; i++) begin
            add_row("check flip", PAT_RAND, KIND_CHECK, i, 0, 1'b0);
        end
        add_row("double data data", PAT_RAND, KIND_DATA_DATA, 0, 116, 1'b0);
        add_row("double data data", PAT_ZERO, KIND_DATA_DATA, 5, 58, 1'b0);
        add_row("double data check", PAT_RAND, KIND_DATA_CHECK, 3, 2, 1'b0);
        add_row("double data check", PAT_ONES, KIND_DATA_CHECK, 100, 7, 1'b0);
        add_row("double check check", PAT_RAND, KIND_CHECK_CHECK, 0, 7, 1'b0);
        add_row("double check check", PAT_RAND, KIND_CHECK_CHECK, 3, 4, 1'b0);
        add_row("bypass data flip", PAT_RAND, KIND_DATA, 42, 0, 1'b1);
        add_row("bypass check flip", PAT_RAND, KIND_CHECK, 6, 0, 1'b1);
        add_row("bypass double", PAT_RAND, KIND_DATA_DATA, 7, 90, 1'b1);
        // 20 words back to back with mixed errors.
        for (int i = 0; i < 20; i++) begin
            a = $urandom % 117;
            b = (a + 1 + ($urandom % 116)) % 117;
            case (i % 3)
                0:       add_row("stream clean", PAT_RAND, KIND_NONE, 0, 0, 1'b0);
                1:       add_row("stream single", PAT_RAND, KIND_DATA, a, 0, 1'b0);
                default: add_row("stream double", PAT_RAND, KIND_DATA_DATA, a, b, 1'b0);
            endcase
        end
    endtask

    task automatic apply_row(input int r);
        ecc_data_t   good_data;
        ecc_data_t   bad_data;
        ecc_parity_t good_par;
        ecc_parity_t bad_par;
        expect_t     e;

        case (tbl_pat[r])
            PAT_ZERO: good_data = '0;
            PAT_ONES: good_data = '1;
            default:  good_data = random_word();
        endcase
        good_par = ref_check_bits(good_data);
        bad_data = good_data;
        bad_par  = good_par;
        case (tbl_kind[r])
            KIND_DATA:  bad_data[tbl_a[r]] = ~bad_data[tbl_a[r]];
            KIND_CHECK: bad_par[tbl_a[r]]  = ~bad_par[tbl_a[r]];
            KIND_DATA_DATA: begin
                bad_data[tbl_a[r]] = ~bad_data[tbl_a[r]];
                bad_data[tbl_b[r]] = ~bad_data[tbl_b[r]];
            end
            KIND_DATA_CHECK: begin
                bad_data[tbl_a[r]] = ~bad_data[tbl_a[r]];
                bad_par[tbl_b[r]]  = ~bad_par[tbl_b[r]];
            end
            KIND_CHECK_CHECK: begin
                bad_par[tbl_a[r]] = ~bad_par[tbl_a[r]];
                bad_par[tbl_b[r]] = ~bad_par[tbl_b[r]];
            end
            default: ;
        endcase

        e.test_id = r;
        e.exp_cyc = cyc + 2;                            // seen two edges after acceptance.
        e.parity  = ref_check_bits(bad_data);           // regenerated from the word as received.
        if (tbl_byp[r]) begin
            e.data = bad_data;
            e.sbit = 1'b0;
            e.dbit = 1'b0;
        end else begin
            case (tbl_kind[r])
                KIND_NONE:  {e.data, e.sbit, e.dbit} = {good_data, 1'b0, 1'b0};
                KIND_DATA:  {e.data, e.sbit, e.dbit} = {good_data, 1'b1, 1'b0};
                KIND_CHECK: {e.data, e.sbit, e.dbit} = {bad_data, 1'b1, 1'b0};
                default:    {e.data, e.sbit, e.dbit} = {bad_data, 1'b0, 1'b1};
            endcase
        end
        exp_q.push_back(e);

        in_valid  = 1'b1;
        data_in   = bad_data;
        parity_in = bad_par;
        bypass    = tbl_byp[r];
    endtask

    task automatic check_field(input string name, input logic [127:0] got,
                               input logic [127:0] exp, input logic [31:0] id);
        assert (got === exp) else begin
            $display("CHECK FAILED test %0d: %s got %h expected %h", id, name, got, exp);
            row_bad = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // output monitor.
    ////////////////////////////////////////

    always @(negedge clk) begin
        expect_t e;

        if (reset) begin
            if (cyc >= 1) begin
                assert (out_valid === 1'b0) else begin
                    $display("CHECK FAILED out_valid got %h expected 0 during reset", out_valid);
                    other_errors = other_errors + 1;
                end
            end
        end else if (out_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("CHECK FAILED out_valid got 1 expected 0 with no word in flight");
                other_errors = other_errors + 1;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                row_bad = 1'b0;
                check_field("latency cycle", 128'(cyc), 128'(e.exp_cyc), e.test_id);
                check_field("data_out", 128'(data_out), 128'(e.data), e.test_id);
                check_field("parity_out", 128'(parity_out), 128'(e.parity), e.test_id);
                check_field("sbit_err", 128'(sbit_err), 128'(e.sbit), e.test_id);
                check_field("dbit_err", 128'(dbit_err), 128'(e.dbit), e.test_id);
                if (row_bad) begin
                    n_fail = n_fail + 1;
                end else begin
                    n_pass = n_pass + 1;
                end
                $display("test %0d %s a=%0d b=%0d: %s", e.test_id, tbl_name[e.test_id],
                         tbl_a[e.test_id], tbl_b[e.test_id], row_bad ? "FAIL" : "ok");
            end
        end else if (exp_q.size() != 0) begin
            assert (cyc <= exp_q[0].exp_cyc) else begin
                e = exp_q.pop_front();
                $display("test %0d: out_valid did not rise two cycles after the word went in",
                         e.test_id);
                n_fail = n_fail + 1;
            end
        end
    end

    ////////////////////////////////////////
    // main sequence.
    ////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        seed_init = $urandom(32'h8f03);
        build_table();

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        #1;

        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        bypass   = 1'b0;

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < TIMEOUT) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out waiting for out_valid with %0d words still in flight.",
                     exp_q.size());
            other_errors = other_errors + 1;
        end
        @(posedge clk);

        $display("%0d tests, %0d passed, %0d failed, %0d other errors",
                 n_rows, n_pass, n_fail, other_errors);
        if (n_fail == 0 && other_errors == 0 && n_pass == n_rows) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
+incdir+sim
common/ecc_pkg.sv
ecc_check/ecc_parity_gen.sv
ecc_check/ecc_check_stage.sv
ecc_correct/ecc_syndrome_decode.sv
ecc_correct/ecc_correct_stage.sv
design/ecc_117_top.sv
sim/ecc_117_tb.sv

//--- Makefile
# Verilator build for the 117-bit SECDED checker.

VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ecc_117_tb
DUT_TOP    = ecc_117_top
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides the result; a crashed run counts as a failure too.
run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run reported failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

lint-dut:
	$(VERILATOR) --lint-only -Wall --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
